// File: adc_capture.sv
`timescale 1ns/1ps

// one adc channel: lane delays plus ddr regrouping
module adc_capture import rp_frontend_pkg::*; (
  input  logic                 clk_250,
  input  logic                 reset_i,
  input  lane_bus_t            lanes_i,   // iddr outputs, one pair per lane
  input  logic [NUM_LANES-1:0] ld_i,
  input  logic [NUM_LANES-1:0] ce_i,
  input  logic [NUM_LANES-1:0] inc_i,
  output adc_sample_t          sample_o,
  output tap_t                 tap0_o     // lane 0 tap for calibration
);

  lane_bus_t   lanes_dly;
  tap_t        taps [NUM_LANES];
  adc_sample_t sample_d;

  //////////////////////////////////////////////////
  // per lane delay
  //////////////////////////////////////////////////

  for (genvar gv = 0; gv < NUM_LANES; gv++)
  begin : g_lane
    lane_delay i_dly (
      .clk_250 (clk_250),
      .reset_i (reset_i),
      .lane_i  (lanes_i[gv]),
      .ld_i    (ld_i[gv]),
      .ce_i    (ce_i[gv]),
      .inc_i   (inc_i[gv]),
      .lane_o  (lanes_dly[gv]),
      .tap_o   (taps[gv])
    );
  end

  // interleave, rising phase to even bits
  always_comb
  begin
    for (int k = 0; k < NUM_LANES; k++)
    begin
      sample_d[2*k]   = lanes_dly[k].rise;
      sample_d[2*k+1] = lanes_dly[k].fall;
    end
  end

  always_ff @(posedge clk_250)
  begin
    if (reset_i)
      sample_o <= '0;
    else
      sample_o <= sample_d;  // tap + 2 cycles from the pins
  end

  assign tap0_o = taps[0];

endmodule

// File: adc_sample_router.sv
`timescale 1ns/1ps

// pad to 16 bits and optionally cross the two channels
module adc_sample_router import rp_frontend_pkg::*; (
  input  logic        clk_250,
  input  logic        reset_i,
  input  logic        swap_i,      // sampled at stage one
  input  adc_sample_t sample0_i,
  input  adc_sample_t sample1_i,
  output out_sample_t adc_dat0_o,
  output out_sample_t adc_dat1_o
);

  out_sample_t pad0, pad1;
  out_sample_t sw0_q, sw1_q;  // stage one

  // two zero lsbs, sample stays msb aligned
  assign pad0 = {sample0_i, 2'b00};
  assign pad1 = {sample1_i, 2'b00};

  always_ff @(posedge clk_250)
  begin
    if (reset_i)
    begin
      sw0_q <= '0;
      sw1_q <= '0;
    end
    else
    begin
      sw0_q <= swap_i ? pad1 : pad0;  // adc b -> ch a when swapped
      sw1_q <= swap_i ? pad0 : pad1;
    end
  end

  // stage two, retiming towards acquisition
  always_ff @(posedge clk_250)
  begin
    if (reset_i)
    begin
      adc_dat0_o <= '0;
      adc_dat1_o <= '0;
    end
    else
    begin
      adc_dat0_o <= sw0_q;
      adc_dat1_o <= sw1_q;
    end
  end

endmodule

// File: hk_regs.sv
`timescale 1ns/1ps

// housekeeping registers on the simple system bus
module hk_regs import rp_frontend_pkg::*; (
  input  logic                         clk_250,
  input  logic                         reset_i,
  // system bus
  input  sys_addr_t                    sys_addr_i,
  input  sys_data_t                    sys_wdata_i,
  input  logic                         sys_wen_i,
  input  logic                         sys_ren_i,
  output sys_data_t                    sys_rdata_o,
  output logic                         sys_ack_o,
  output logic                         sys_err_o,
  // control
  output logic                         swap_o,
  output logic [LED_BITS-1:0]          led_o,
  // idelay control with channel 0 in the low lanes
  output logic [NUM_CH*NUM_LANES-1:0]  idly_ld_o,
  output logic [NUM_CH*NUM_LANES-1:0]  idly_ce_o,
  output logic [NUM_CH*NUM_LANES-1:0]  idly_inc_o,
  input  tap_t                         tap0_ch0_i,
  input  tap_t                         tap0_ch1_i,
  // expansion connector
  input  exp_t                         exp_p_dat_i,
  input  exp_t                         exp_n_dat_i,
  output exp_t                         exp_p_dat_o,
  output exp_t                         exp_p_dir_o,  // 1 = drive pin
  output exp_t                         exp_n_dat_o,
  output exp_t                         exp_n_dir_o
);

  logic                        dly_wr;
  logic [NUM_CH*NUM_LANES-1:0] dly_mask;
  exp_t                        exp_p_meta, exp_p_sync;
  exp_t                        exp_n_meta, exp_n_sync;
  sys_data_t                   rdata_d;
  logic                        err_d;

  //////////////////////////////////////////////////
  // writable registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_250)
  begin
    if (reset_i)
    begin
      swap_o      <= 1'b1;  // channels crossed by default
      led_o       <= '0;
      exp_p_dat_o <= '0;
      exp_p_dir_o <= '0;    // all pins input
      exp_n_dat_o <= '0;
      exp_n_dir_o <= '0;
    end
    else if (sys_wen_i)
    begin
      case (sys_addr_i)
        REG_CTRL:      swap_o      <= sys_wdata_i[0];
        REG_LED:       led_o       <= sys_wdata_i[LED_BITS-1:0];
        REG_EXP_P_OUT: exp_p_dat_o <= sys_wdata_i[EXP_BITS-1:0];
        REG_EXP_P_DIR: exp_p_dir_o <= sys_wdata_i[EXP_BITS-1:0];
        REG_EXP_N_OUT: exp_n_dat_o <= sys_wdata_i[EXP_BITS-1:0];
        REG_EXP_N_DIR: exp_n_dir_o <= sys_wdata_i[EXP_BITS-1:0];
        default: ;  // nothing stored for read only or unmapped
      endcase
    end
  end

  //////////////////////////////////////////////////
  // delay command pulses
  //////////////////////////////////////////////////

  assign dly_wr   = sys_wen_i && (sys_addr_i == REG_DLY_CMD);
  assign dly_mask = sys_wdata_i[NUM_CH*NUM_LANES-1:0];

  // single cycle right after the write
  always_ff @(posedge clk_250)
  begin
    if (reset_i)
    begin
      idly_ld_o  <= '0;
      idly_ce_o  <= '0;
      idly_inc_o <= '0;
    end
    else
    begin
      idly_ld_o  <= (dly_wr && sys_wdata_i[DLY_LD_BIT]) ? dly_mask : '0;
      idly_ce_o  <= (dly_wr && !sys_wdata_i[DLY_LD_BIT]) ? dly_mask : '0;  // no step on load
      idly_inc_o <= (dly_wr && sys_wdata_i[DLY_INC_BIT]) ? dly_mask : '0;
    end
  end

  // two flop sync for the expansion pins
  always_ff @(posedge clk_250)
  begin
    exp_p_meta <= exp_p_dat_i;
    exp_n_meta <= exp_n_dat_i;
    exp_p_sync <= exp_p_meta;
    exp_n_sync <= exp_n_meta;
  end

  //////////////////////////////////////////////////
  // read decode and bus response
  //////////////////////////////////////////////////

  always_comb
  begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (sys_addr_i)
      REG_ID:        rdata_d = FRONTEND_ID;
      REG_CTRL:      rdata_d = sys_data_t'(swap_o);
      REG_LED:       rdata_d = sys_data_t'(led_o);
      REG_DLY_CMD:   err_d   = sys_ren_i;  // write only so reads fault
      REG_DLY_CNT:   rdata_d = sys_data_t'({tap0_ch1_i, 3'b000, tap0_ch0_i});
      REG_EXP_P_OUT: rdata_d = sys_data_t'(exp_p_dat_o);
      REG_EXP_P_DIR: rdata_d = sys_data_t'(exp_p_dir_o);
      REG_EXP_N_OUT: rdata_d = sys_data_t'(exp_n_dat_o);
      REG_EXP_N_DIR: rdata_d = sys_data_t'(exp_n_dir_o);
      REG_EXP_IN:    rdata_d = {7'b0, exp_n_sync, 7'b0, exp_p_sync};
      default:       err_d   = 1'b1;   // unmapped
    endcase
  end

  always_ff @(posedge clk_250)
  begin
    if (reset_i)
    begin
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i || sys_ren_i;  // fixed one cycle response
      sys_err_o <= (sys_wen_i || sys_ren_i) && err_d;
    end
  end

  // data only meaningful together with ack
  always_ff @(posedge clk_250)
    sys_rdata_o <= sys_ren_i ? rdata_d : '0;

  // one kind of request per cycle from the master
  a_no_dual_req: assert property (
    @(posedge clk_250) disable iff (reset_i)
    !(sys_wen_i && sys_ren_i)
  );

  // ack only after a request and never overlapped by the next request
  a_ack_after_req: assert property (
    @(posedge clk_250) disable iff (reset_i)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i) && !(sys_wen_i || sys_ren_i)
  );

endmodule

// File: lane_delay.sv
`timescale 1ns/1ps

// behavioral tap delay for one adc lane
// stands in for the idelay primitive plus its counter
module lane_delay import rp_frontend_pkg::*; (
  input  logic       clk_250,
  input  logic       reset_i,
  input  lane_pair_t lane_i,   // rise/fall pair from the pins
  input  logic       ld_i,     // tap count back to 0
  input  logic       ce_i,     // step the tap count
  input  logic       inc_i,    // step direction
  output lane_pair_t lane_o,
  output tap_t       tap_o
);

  lane_pair_t hist_q [NUM_TAPS];  // hist_q[k] = input k+1 cycles ago
  tap_t       tap_q;

  //////////////////////////////////////////////////
  // tap counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk_250)
  begin
    if (reset_i)
      tap_q <= '0;
    else if (ld_i)
      tap_q <= '0;               // load beats enable
    else if (ce_i)
    begin
      if (inc_i)
        tap_q <= tap_q + 1'b1;   // wraps 31 -> 0
      else
        tap_q <= tap_q - 1'b1;   // wraps 0 -> 31
    end
  end

  //////////////////////////////////////////////////
  // delay line
  //////////////////////////////////////////////////

  always_ff @(posedge clk_250)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < NUM_TAPS; i++)
        hist_q[i] <= '0;
    end
    else
    begin
      hist_q[0] <= lane_i;
      for (int i = 1; i < NUM_TAPS; i++)
        hist_q[i] <= hist_q[i-1];  // age by one cycle
    end
  end

  // tap 0 still gives one cycle of delay
  assign lane_o = hist_q[tap_q];
  assign tap_o  = tap_q;

  // counter must stay defined, the readback path depends on it
  a_tap_known: assert property (
    @(posedge clk_250) disable iff (reset_i)
    !$isunknown(tap_o)
  );

endmodule

// File: rp_frontend.f
rp_frontend_pkg.sv
lane_delay.sv
adc_capture.sv
adc_sample_router.sv
hk_regs.sv
rp_frontend_top.sv
tb_rp_frontend.sv

// File: rp_frontend_pkg.sv
package rp_frontend_pkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////

  localparam int NUM_CH      = 2;   // adc channels
  localparam int NUM_LANES   = 7;   // ddr lanes per channel
  localparam int SAMPLE_BITS = 14;  // raw adc word
  localparam int OUT_BITS    = 16;  // padded word towards acquisition
  localparam int TAP_BITS    = 5;
  localparam int NUM_TAPS    = 32;  // 2**TAP_BITS
  localparam int EXP_BITS    = 9;   // expansion pins per side
  localparam int LED_BITS    = 8;

  localparam logic [31:0] FRONTEND_ID = 32'h5250_4645;  // ascii "RPFE"

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  // one ddr lane, as seen after the iddr pair
  typedef struct packed {
    logic fall;  // second phase, lands in odd sample bit
    logic rise;  // first phase, lands in even sample bit
  } lane_pair_t;

  typedef lane_pair_t [NUM_LANES-1:0] lane_bus_t;  // all lanes of one channel

  typedef logic [SAMPLE_BITS-1:0] adc_sample_t;
  typedef logic [OUT_BITS-1:0]    out_sample_t;
  typedef logic [TAP_BITS-1:0]    tap_t;
  typedef logic [31:0]            sys_addr_t;
  typedef logic [31:0]            sys_data_t;
  typedef logic [EXP_BITS-1:0]    exp_t;

  //////////////////////////////////////////////////
  // housekeeping register map
  //////////////////////////////////////////////////

  localparam sys_addr_t REG_ID        = 32'h00;
  localparam sys_addr_t REG_CTRL      = 32'h04;  // bit 0 swap enable
  localparam sys_addr_t REG_LED       = 32'h08;
  localparam sys_addr_t REG_DLY_CMD   = 32'h0C;  // write only
  localparam sys_addr_t REG_DLY_CNT   = 32'h10;  // lane 0 taps of both channels
  localparam sys_addr_t REG_EXP_P_OUT = 32'h14;
  localparam sys_addr_t REG_EXP_P_DIR = 32'h18;
  localparam sys_addr_t REG_EXP_N_OUT = 32'h1C;
  localparam sys_addr_t REG_EXP_N_DIR = 32'h20;
  localparam sys_addr_t REG_EXP_IN    = 32'h24;

  // delay command fields, mask sits in the low bits
  localparam int DLY_INC_BIT = 16;  // 1 increment, 0 decrement
  localparam int DLY_LD_BIT  = 17;  // reset tap count

endpackage

// File: rp_frontend_top.sv
`timescale 1ns/1ps

// adc front end: capture, routing and housekeeping on clk_250
module rp_frontend_top import rp_frontend_pkg::*; (
  input  logic                clk_250,
  input  logic                reset_i,
  // adc lanes after the iddr pair
  input  lane_bus_t           adc_lane0_i,
  input  lane_bus_t           adc_lane1_i,
  output out_sample_t         adc_dat0_o,
  output out_sample_t         adc_dat1_o,
  output logic [LED_BITS-1:0] led_o,
  // system bus
  input  sys_addr_t           sys_addr_i,
  input  sys_data_t           sys_wdata_i,
  input  logic                sys_wen_i,
  input  logic                sys_ren_i,
  output sys_data_t           sys_rdata_o,
  output logic                sys_ack_o,
  output logic                sys_err_o,
  // expansion connector, split into in / out / dir
  input  exp_t                exp_p_dat_i,
  input  exp_t                exp_n_dat_i,
  output exp_t                exp_p_dat_o,
  output exp_t                exp_p_dir_o,
  output exp_t                exp_n_dat_o,
  output exp_t                exp_n_dir_o
);

  logic [NUM_CH*NUM_LANES-1:0] idly_ld;
  logic [NUM_CH*NUM_LANES-1:0] idly_ce;
  logic [NUM_CH*NUM_LANES-1:0] idly_inc;
  tap_t                        tap0_ch0, tap0_ch1;
  adc_sample_t                 sample0, sample1;
  logic                        swap;

  //////////////////////////////////////////////////
  // adc capture, lanes 0..6 ch0, 7..13 ch1
  //////////////////////////////////////////////////

  adc_capture i_cap0 (
    .clk_250  (clk_250),
    .reset_i  (reset_i),
    .lanes_i  (adc_lane0_i),
    .ld_i     (idly_ld[NUM_LANES-1:0]),
    .ce_i     (idly_ce[NUM_LANES-1:0]),
    .inc_i    (idly_inc[NUM_LANES-1:0]),
    .sample_o (sample0),
    .tap0_o   (tap0_ch0)
  );

  adc_capture i_cap1 (
    .clk_250  (clk_250),
    .reset_i  (reset_i),
    .lanes_i  (adc_lane1_i),
    .ld_i     (idly_ld[2*NUM_LANES-1:NUM_LANES]),
    .ce_i     (idly_ce[2*NUM_LANES-1:NUM_LANES]),
    .inc_i    (idly_inc[2*NUM_LANES-1:NUM_LANES]),
    .sample_o (sample1),
    .tap0_o   (tap0_ch1)
  );

  adc_sample_router i_route (
    .clk_250    (clk_250),
    .reset_i    (reset_i),
    .swap_i     (swap),
    .sample0_i  (sample0),
    .sample1_i  (sample1),
    .adc_dat0_o (adc_dat0_o),
    .adc_dat1_o (adc_dat1_o)
  );

  //////////////////////////////////////////////////
  // housekeeping
  //////////////////////////////////////////////////

  hk_regs i_hk (
    .clk_250     (clk_250),
    .reset_i     (reset_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .swap_o      (swap),
    .led_o       (led_o),
    .idly_ld_o   (idly_ld),
    .idly_ce_o   (idly_ce),
    .idly_inc_o  (idly_inc),
    .tap0_ch0_i  (tap0_ch0),
    .tap0_ch1_i  (tap0_ch1),
    .exp_p_dat_i (exp_p_dat_i),
    .exp_n_dat_i (exp_n_dat_i),
    .exp_p_dat_o (exp_p_dat_o),
    .exp_p_dir_o (exp_p_dir_o),
    .exp_n_dat_o (exp_n_dat_o),
    .exp_n_dir_o (exp_n_dir_o)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_rp_frontend \
    -f rp_frontend.f -o sim_rp_frontend &&
  ./obj_dir/sim_rp_frontend | tee /dev/stderr | grep -q "Simulation PASSED" &&
  echo "run ok" || { echo "run failed"; exit 1; }

// File: tb_rp_frontend.sv
`timescale 1ns/1ps

module tb_rp_frontend import rp_frontend_pkg::*; ();

  localparam int          HIST        = 64;  // lane history deeper than max tap plus pipe
  localparam int          PIPE        = 4;   // pins to adc_dat_o at tap 0
  localparam int          SETTLE      = 8;   // drain samples older than a change
  localparam int          ACK_TIMEOUT = 16;
  localparam logic [31:0] SEED        = 32'hed83_b22b;

  // dut side
  logic                clk_250     = 1'b0;
  logic                reset_i     = 1'b1;
  lane_bus_t           adc_lane0_i = '0;
  lane_bus_t           adc_lane1_i = '0;
  out_sample_t         adc_dat0_o, adc_dat1_o;
  logic [LED_BITS-1:0] led_o;
  sys_addr_t           sys_addr_i  = '0;
  sys_data_t           sys_wdata_i = '0;
  logic                sys_wen_i   = 1'b0;
  logic                sys_ren_i   = 1'b0;
  sys_data_t           sys_rdata_o;
  logic                sys_ack_o, sys_err_o;
  exp_t                exp_p_dat_i = '0;
  exp_t                exp_n_dat_i = '0;
  exp_t                exp_p_dat_o, exp_p_dir_o, exp_n_dat_o, exp_n_dir_o;

  // bookkeeping
  int                    err_count     = 0;
  int                    check_count   = 0;
  int                    test_count    = 0;
  int                    test_err_base = 0;
  int                    cyc           = 0;     // index of newest driven lane word
  logic                  stim_en       = 1'b0;
  logic                  cmp_en        = 1'b0;
  logic                  swap_model    = 1'b1;  // crossed out of reset
  tap_t                  tap_model0    = '0;    // ch0 lane 0
  tap_t                  tap_model1    = '0;    // ch1 lane 0
  logic [31:0]           rng           = SEED;
  lane_bus_t             next0, next1;
  lane_bus_t             hist0 [HIST]  = '{default: '0};
  lane_bus_t             hist1 [HIST]  = '{default: '0};
  logic [2*OUT_BITS-1:0] route_exp;             // {dat1, dat0}
  sys_data_t             rd;
  logic                  bus_err;
  sys_data_t             led_val, p_out, p_dir, n_out, n_dir;
  exp_t                  p_in, n_in;

  rp_frontend_top UUT (
    .clk_250     (clk_250),
    .reset_i     (reset_i),
    .adc_lane0_i (adc_lane0_i),
    .adc_lane1_i (adc_lane1_i),
    .adc_dat0_o  (adc_dat0_o),
    .adc_dat1_o  (adc_dat1_o),
    .led_o       (led_o),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .exp_p_dat_i (exp_p_dat_i),
    .exp_n_dat_i (exp_n_dat_i),
    .exp_p_dat_o (exp_p_dat_o),
    .exp_p_dir_o (exp_p_dir_o),
    .exp_n_dat_o (exp_n_dat_o),
    .exp_n_dir_o (exp_n_dir_o)
  );

  always #10 clk_250 = ~clk_250;  // 20 ns

  //////////////////////////////////////////////////
  // models
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // one tap counter step for an addressed lane
  function automatic tap_t tap_step(input tap_t t, input logic ld, input logic inc);
    if (ld)
      return '0;         // load wins
    else if (inc)
      return t + 1'b1;   // 31 -> 0
    else
      return t - 1'b1;   // 0 -> 31
  endfunction

  // routed pair seen at adc_dat_o after edge m with lane 0 aged by its tap
  function automatic logic [2*OUT_BITS-1:0] expected_route(input int m, input logic swap,
                                                           input tap_t t0, input tap_t t1);
    adc_sample_t s0, s1;
    out_sample_t p0, p1;
    lane_pair_t  q0, q1;
    int          age0, age1;
    for (int k = 0; k < NUM_LANES; k++)
    begin
      age0 = (k == 0) ? PIPE + int'(t0) : PIPE;
      age1 = (k == 0) ? PIPE + int'(t1) : PIPE;
      q0 = hist0[(m + HIST - age0) % HIST][k];
      q1 = hist1[(m + HIST - age1) % HIST][k];
      s0[2*k]   = q0.rise;  // even bit rising phase
      s0[2*k+1] = q0.fall;
      s1[2*k]   = q1.rise;
      s1[2*k+1] = q1.fall;
    end
    p0 = {s0, 2'b00};
    p1 = {s1, 2'b00};
    return swap ? {p0, p1} : {p1, p0};
  endfunction

  function automatic sys_data_t dly_cnt_expected();
    return (sys_data_t'(tap_model1) << 8) | sys_data_t'(tap_model0);
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_sample(input string name, input out_sample_t got, input out_sample_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_word(input string name, input sys_data_t got, input sys_data_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_exp(input string name, input exp_t got, input exp_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // bus and sequencing tasks
  //////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $finish;
  endtask

  // ack expected in the cycle after the request
  task automatic wait_ack(input sys_addr_t addr, output sys_data_t data, output logic err);
    int waited;
    waited = 0;
    @(negedge clk_250);
    while (!sys_ack_o && waited < ACK_TIMEOUT)
    begin
      waited++;
      @(negedge clk_250);
    end
    if (!sys_ack_o)
      abort_run($sformatf("no bus acknowledge for address %h", addr));
    else
    begin
      data = sys_rdata_o;
      err  = sys_err_o;
      check_word("sys_ack_o extra delay", sys_data_t'(waited), '0);
      @(negedge clk_250);
      check_word("sys_ack_o", sys_data_t'(sys_ack_o), '0);  // one cycle pulse
    end
  endtask

  task automatic bus_write(input sys_addr_t addr, input sys_data_t data, output logic err);
    sys_data_t unused;
    @(posedge clk_250);
    sys_addr_i  <= addr;
    sys_wdata_i <= data;
    sys_wen_i   <= 1'b1;
    @(posedge clk_250);
    sys_wen_i   <= 1'b0;  // single cycle strobe
    wait_ack(addr, unused, err);
  endtask

  task automatic bus_read(input sys_addr_t addr, output sys_data_t data, output logic err);
    @(posedge clk_250);
    sys_addr_i <= addr;
    sys_ren_i  <= 1'b1;
    @(posedge clk_250);
    sys_ren_i  <= 1'b0;
    wait_ack(addr, data, err);
  endtask

  task automatic delay_cmd(input logic [NUM_CH*NUM_LANES-1:0] mask, input logic inc,
                           input logic ld);
    bus_write(REG_DLY_CMD, {14'b0, ld, inc, 2'b00, mask}, bus_err);
    check_word("REG_DLY_CMD write sys_err_o", sys_data_t'(bus_err), '0);
    if (mask[0])
      tap_model0 = tap_step(tap_model0, ld, inc);
    if (mask[NUM_LANES])
      tap_model1 = tap_step(tap_model1, ld, inc);
  endtask

  // flags change on posedge and the compare runs on negedge
  task automatic compare_window(input int cycles);
    repeat (SETTLE) @(posedge clk_250);
    cmp_en = 1'b1;
    repeat (cycles) @(posedge clk_250);
    cmp_en = 1'b0;
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("test %0d %s done, %0d errors", test_count, name, err_count - test_err_base);
    test_err_base = err_count;
  endtask

  //////////////////////////////////////////////////
  // lane stimulus and sample compare
  //////////////////////////////////////////////////

  always @(posedge clk_250)
  begin
    if (stim_en)
    begin
      rng   = xorshift(rng);
      next0 = rng[13:0];
      next1 = rng[27:14];
    end
    else
    begin
      next0 = '0;
      next1 = '0;
    end
    adc_lane0_i <= next0;
    adc_lane1_i <= next1;
    cyc = cyc + 1;
    hist0[cyc % HIST] = next0;  // word driven at edge cyc
    hist1[cyc % HIST] = next1;
  end

  always @(negedge clk_250)
  begin
    if (cmp_en)
    begin
      route_exp = expected_route(cyc, swap_model, tap_model0, tap_model1);
      check_sample("adc_dat0_o", adc_dat0_o, route_exp[OUT_BITS-1:0]);
      check_sample("adc_dat1_o", adc_dat1_o, route_exp[2*OUT_BITS-1:OUT_BITS]);
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    repeat (5) @(posedge clk_250);
    reset_i <= 1'b0;

    // reset state
    @(negedge clk_250);
    check_word("led_o", sys_data_t'(led_o), '0);
    check_exp("exp_p_dat_o", exp_p_dat_o, '0);
    check_exp("exp_p_dir_o", exp_p_dir_o, '0);
    check_exp("exp_n_dat_o", exp_n_dat_o, '0);
    check_exp("exp_n_dir_o", exp_n_dir_o, '0);
    check_word("sys_ack_o", sys_data_t'(sys_ack_o), '0);
    check_word("sys_err_o", sys_data_t'(sys_err_o), '0);
    bus_read(REG_CTRL, rd, bus_err);
    check_word("REG_CTRL", rd, 32'd1);
    check_word("REG_CTRL sys_err_o", sys_data_t'(bus_err), '0);
    bus_read(REG_DLY_CNT, rd, bus_err);
    check_word("REG_DLY_CNT", rd, '0);
    bus_read(REG_ID, rd, bus_err);
    check_word("REG_ID", rd, FRONTEND_ID);
    finish_test("reset state");

    // swapped path is the default after reset
    stim_en = 1'b1;
    compare_window(200);
    finish_test("swapped data path");

    // straight path
    bus_write(REG_CTRL, 32'd0, bus_err);
    swap_model = 1'b0;
    compare_window(200);
    bus_write(REG_CTRL, 32'd1, bus_err);
    swap_model = 1'b1;
    finish_test("unswapped data path");

    // tap steps on lane 0 of each channel
    repeat (3) delay_cmd(14'h0001, 1'b1, 1'b0);
    bus_read(REG_DLY_CNT, rd, bus_err);
    check_word("REG_DLY_CNT", rd, dly_cnt_expected());
    check_word("REG_DLY_CNT ch0 field", rd & 32'h1F, 32'd3);
    compare_window(100);
    delay_cmd(14'h0080, 1'b0, 1'b0);  // down from 0
    bus_read(REG_DLY_CNT, rd, bus_err);
    check_word("REG_DLY_CNT", rd, dly_cnt_expected());
    check_word("REG_DLY_CNT ch1 field", (rd >> 8) & 32'h1F, 32'd31);
    compare_window(100);              // 35 cycle lag on ch1 lane 0
    delay_cmd(14'h0081, 1'b0, 1'b1);  // load both back to 0
    bus_read(REG_DLY_CNT, rd, bus_err);
    check_word("REG_DLY_CNT", rd, '0);
    compare_window(60);
    finish_test("delay taps");

    // register readback, ports and error responses
    @(negedge clk_250);
    stim_en = 1'b0;  // rng free for the main sequence now
    rng     = xorshift(rng);
    led_val = rng;
    rng     = xorshift(rng);
    p_out   = rng;
    rng     = xorshift(rng);
    p_dir   = rng;
    rng     = xorshift(rng);
    n_out   = rng;
    rng     = xorshift(rng);
    n_dir   = rng;
    bus_write(REG_LED, led_val, bus_err);
    check_word("REG_LED write sys_err_o", sys_data_t'(bus_err), '0);
    bus_write(REG_EXP_P_OUT, p_out, bus_err);
    bus_write(REG_EXP_P_DIR, p_dir, bus_err);
    bus_write(REG_EXP_N_OUT, n_out, bus_err);
    bus_write(REG_EXP_N_DIR, n_dir, bus_err);
    check_word("led_o", sys_data_t'(led_o), sys_data_t'(led_val[LED_BITS-1:0]));
    check_exp("exp_p_dat_o", exp_p_dat_o, exp_t'(p_out));
    check_exp("exp_p_dir_o", exp_p_dir_o, exp_t'(p_dir));
    check_exp("exp_n_dat_o", exp_n_dat_o, exp_t'(n_out));
    check_exp("exp_n_dir_o", exp_n_dir_o, exp_t'(n_dir));
    bus_read(REG_LED, rd, bus_err);
    check_word("REG_LED", rd, sys_data_t'(led_val[LED_BITS-1:0]));
    check_word("REG_LED read sys_err_o", sys_data_t'(bus_err), '0);
    bus_read(REG_EXP_P_OUT, rd, bus_err);
    check_word("REG_EXP_P_OUT", rd, sys_data_t'(exp_t'(p_out)));
    bus_read(REG_EXP_P_DIR, rd, bus_err);
    check_word("REG_EXP_P_DIR", rd, sys_data_t'(exp_t'(p_dir)));
    bus_read(REG_EXP_N_OUT, rd, bus_err);
    check_word("REG_EXP_N_OUT", rd, sys_data_t'(exp_t'(n_out)));
    bus_read(REG_EXP_N_DIR, rd, bus_err);
    check_word("REG_EXP_N_DIR", rd, sys_data_t'(exp_t'(n_dir)));
    bus_read(32'h40, rd, bus_err);    // unmapped
    check_word("unmapped read sys_err_o", sys_data_t'(bus_err), 32'd1);
    check_word("unmapped read sys_rdata_o", rd, '0);
    bus_write(32'h44, 32'hFFFF_FFFF, bus_err);
    check_word("unmapped write sys_err_o", sys_data_t'(bus_err), 32'd1);
    bus_read(REG_DLY_CMD, rd, bus_err);  // write only
    check_word("REG_DLY_CMD read sys_err_o", sys_data_t'(bus_err), 32'd1);
    check_word("REG_DLY_CMD read sys_rdata_o", rd, '0);
    finish_test("registers and errors");

    // expansion input through the synchronizer
    for (int i = 0; i < 8; i++)
    begin
      @(posedge clk_250);
      rng          = xorshift(rng);
      p_in         = rng[8:0];
      n_in         = rng[24:16];
      exp_p_dat_i <= p_in;
      exp_n_dat_i <= n_in;
      repeat (3) @(posedge clk_250);  // pins stable 3 cycles
      bus_read(REG_EXP_IN, rd, bus_err);
      check_word("REG_EXP_IN", rd, (sys_data_t'(n_in) << 16) | sys_data_t'(p_in));
    end
    finish_test("expansion input");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
